// ==== build.f ====
+incdir+.
icache_pkg.sv
icache_lookup.sv
icache_refill.sv
icache_resp.sv
icache_top.sv
tb_icache_properties.sv
tb_icache.sv

// ==== icache_lookup.sv ====
//////////////////////////////////////////////////
// Lookup stage: tag, valid and data arrays,
// one registered request and the hit/miss check
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_lookup
(
   input  logic                   clk,
   input  logic                   i_arst_n,
   input  logic                   i_req_valid,
   input  icache_pkg::fetch_req_t i_req,
   output logic                   o_req_ready,
   output logic                   o_miss_valid,
   output icache_pkg::miss_req_t  o_miss,
   input  logic                   i_miss_ready,
   input  icache_pkg::line_wr_t   i_line_wr,
   output logic                   o_hit_valid,
   output icache_pkg::fetch_rsp_t o_hit,
   input  logic                   i_hit_ready
);

   // Storage, read combinationally
   logic [`IC_TAG_W-1:0]   tag_q   [`IC_WAYS][`IC_SETS];
   logic [`IC_SETS-1:0]    valid_q [`IC_WAYS];
   logic [`IC_DW-1:0]      data_q  [`IC_WAYS][`IC_SETS*`IC_BEATS];

   logic                   open_q;      // Set from the first edge after reset
   logic                   busy_q;
   logic                   miss_sent_q; // Refill running for this request
   icache_pkg::fetch_req_t req_q;

   logic [`IC_TAG_W-1:0]   req_tag;
   logic [`IC_P_SETS-1:0]  req_set;
   logic [`IC_P_BEATS-1:0] req_word;
   logic [`IC_WAYS-1:0]    hit_vec;
   logic [`IC_DW-1:0]      hit_word;
   logic                   hit;
   logic                   req_take;
   logic                   hit_take;

   assign req_tag  = req_q.addr[`IC_AW-1 -: `IC_TAG_W];
   assign req_set  = req_q.addr[`IC_P_LINE +: `IC_P_SETS];
   assign req_word = req_q.addr[`IC_P_WORD +: `IC_P_BEATS];

   // Compare both ways, pick the matching word
   always_comb
      begin
         hit_word = '0;
         for (int w = 0; w < `IC_WAYS; w++)
            begin
               hit_vec[w] = valid_q[w][req_set] & (tag_q[w][req_set] == req_tag);
               if (hit_vec[w])
                  hit_word = data_q[w][{req_set, req_word}];
            end
      end

   assign hit = |hit_vec;

   assign o_hit_valid = busy_q & hit;
   assign o_hit.addr  = req_q.addr;
   assign o_hit.insn  = hit_word;

   assign hit_take    = o_hit_valid & i_hit_ready;
   assign o_req_ready = open_q & (~busy_q | hit_take); // Empty, or leaving now
   assign req_take    = i_req_valid & o_req_ready;

   // Miss is offered once, then the request waits for its line
   assign o_miss_valid     = busy_q & ~hit & ~miss_sent_q;
   assign o_miss.line_addr = {req_q.addr[`IC_AW-1:`IC_P_LINE], {`IC_P_LINE{1'b0}}};

   always_ff @(posedge clk or negedge i_arst_n)
      if (!i_arst_n)
         begin
            open_q      <= 1'b0;
            busy_q      <= 1'b0;
            miss_sent_q <= 1'b0;
         end
      else
         begin
            open_q <= 1'b1;
            if (req_take)
               busy_q <= 1'b1;
            else if (hit_take)
               busy_q <= 1'b0;

            if (hit_take)
               miss_sent_q <= 1'b0;
            else if (o_miss_valid & i_miss_ready)
               miss_sent_q <= 1'b1;
         end

   always_ff @(posedge clk)
      if (req_take)
         req_q <= i_req;

   // Early beats drop the victim's valid bit, the last one sets it
   always_ff @(posedge clk or negedge i_arst_n)
      if (!i_arst_n)
         begin
            for (int w = 0; w < `IC_WAYS; w++)
               valid_q[w] <= '0;
         end
      else if (i_line_wr.we)
         begin
            for (int w = 0; w < `IC_WAYS; w++)
               if (i_line_wr.way[w])
                  valid_q[w][i_line_wr.set_idx] <= i_line_wr.tag_we;
         end

   always_ff @(posedge clk)
      if (i_line_wr.we)
         begin
            for (int w = 0; w < `IC_WAYS; w++)
               if (i_line_wr.way[w])
                  begin
                     data_q[w][{i_line_wr.set_idx, i_line_wr.word_idx}] <= i_line_wr.data;
                     if (i_line_wr.tag_we)
                        tag_q[w][i_line_wr.set_idx] <= i_line_wr.tag;
                  end
         end

endmodule

// ==== icache_pkg.sv ====
//////////////////////////////////////////////////
// Instruction cache shared types
// Fetch, refill and read channel payloads
//////////////////////////////////////////////////
`include "icache_settings.svh"

package icache_pkg;

   typedef struct packed {
      logic [`IC_AW-1:0]      addr;      // Word aligned
   } fetch_req_t;

   typedef struct packed {
      logic [`IC_AW-1:0]      addr;
      logic [`IC_DW-1:0]      insn;
   } fetch_rsp_t;

   typedef struct packed {
      logic [`IC_AW-1:0]      line_addr; // Offset bits zero
   } miss_req_t;

   // One beat written into the arrays
   typedef struct packed {
      logic                   we;
      logic [`IC_WAYS-1:0]    way;       // One-hot victim
      logic [`IC_P_SETS-1:0]  set_idx;
      logic [`IC_P_BEATS-1:0] word_idx;
      logic [`IC_DW-1:0]      data;
      logic                   tag_we;    // Last beat, line becomes valid
      logic [`IC_TAG_W-1:0]   tag;
   } line_wr_t;

   typedef struct packed {
      logic [`IC_AW-1:0]      addr;
      logic [7:0]             len;       // Beats minus one
   } ar_req_t;

   typedef struct packed {
      logic [`IC_DW-1:0]      data;
      logic                   last;
   } r_beat_t;

   typedef enum logic [1:0] {
      R_IDLE,
      R_ADDR,
      R_DATA
   } refill_state_e;

endpackage

// ==== icache_refill.sv ====
//////////////////////////////////////////////////
// Refill engine: burst read of one line into the
// victim way, round-robin victim pointer
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_refill
(
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  logic                  i_miss_valid,
   input  icache_pkg::miss_req_t i_miss,
   output logic                  o_miss_ready,
   output logic                  o_ar_valid,
   output icache_pkg::ar_req_t   o_ar,
   input  logic                  i_ar_ready,
   input  logic                  i_r_valid,
   input  icache_pkg::r_beat_t   i_r,
   output logic                  o_r_ready,
   output icache_pkg::line_wr_t  o_line_wr
);

   icache_pkg::refill_state_e state_q;
   icache_pkg::refill_state_e state_nxt;
   icache_pkg::miss_req_t     line_q;
   logic [`IC_P_BEATS-1:0]    beat_q;     // Word index of the next beat
   logic [`IC_WAYS-1:0]       victim_q;   // One-hot, rotates per line
   logic                      miss_take;
   logic                      ar_take;
   logic                      r_take;
   logic                      r_last;

   assign o_miss_ready = (state_q == icache_pkg::R_IDLE);
   assign o_ar_valid   = (state_q == icache_pkg::R_ADDR);
   assign o_r_ready    = (state_q == icache_pkg::R_DATA);

   assign miss_take = i_miss_valid & o_miss_ready;
   assign ar_take   = o_ar_valid & i_ar_ready;
   assign r_take    = i_r_valid & o_r_ready;
   assign r_last    = r_take & i_r.last;

   always_comb
      begin
         state_nxt = state_q;
         case (state_q)
            icache_pkg::R_IDLE:
               if (miss_take)
                  state_nxt = icache_pkg::R_ADDR;
            icache_pkg::R_ADDR:
               if (ar_take)
                  state_nxt = icache_pkg::R_DATA;
            icache_pkg::R_DATA:
               if (r_last)
                  state_nxt = icache_pkg::R_IDLE;
            default:
               state_nxt = icache_pkg::R_IDLE;
         endcase
      end

   always_ff @(posedge clk or negedge i_arst_n)
      if (!i_arst_n)
         begin
            state_q  <= icache_pkg::R_IDLE;
            beat_q   <= '0;
            victim_q <= {{(`IC_WAYS-1){1'b0}}, 1'b1}; // Way 0 first
         end
      else
         begin
            state_q <= state_nxt;
            if (miss_take)
               beat_q <= '0;
            else if (r_take)
               beat_q <= beat_q + 1'b1;
            // Next way once the line is complete
            if (r_last)
               victim_q <= {victim_q[`IC_WAYS-2:0], victim_q[`IC_WAYS-1]};
         end

   // Held stable from the miss until the next one
   always_ff @(posedge clk)
      if (miss_take)
         line_q <= i_miss;

   assign o_ar.addr = line_q.line_addr;
   assign o_ar.len  = 8'(`IC_BEATS - 1);

   assign o_line_wr.we       = r_take;
   assign o_line_wr.way      = victim_q;
   assign o_line_wr.set_idx  = line_q.line_addr[`IC_P_LINE +: `IC_P_SETS];
   assign o_line_wr.word_idx = beat_q;      // Beats come in ascending order
   assign o_line_wr.data     = i_r.data;
   assign o_line_wr.tag_we   = r_last;
   assign o_line_wr.tag      = line_q.line_addr[`IC_AW-1 -: `IC_TAG_W];

endmodule

// ==== icache_resp.sv ====
//////////////////////////////////////////////////
// Response stage: one-entry output register
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_resp
(
   input  logic                   clk,
   input  logic                   i_arst_n,
   input  logic                   i_hit_valid,
   input  icache_pkg::fetch_rsp_t i_hit,
   output logic                   o_hit_ready,
   output logic                   o_rsp_valid,
   output icache_pkg::fetch_rsp_t o_rsp,
   input  logic                   i_rsp_ready
);

   logic                   valid_q;
   icache_pkg::fetch_rsp_t rsp_q;

   // Free when empty or draining this cycle
   assign o_hit_ready = ~valid_q | i_rsp_ready;

   always_ff @(posedge clk or negedge i_arst_n)
      if (!i_arst_n)
         valid_q <= 1'b0;
      else if (o_hit_ready)
         valid_q <= i_hit_valid;

   // Payload held under back-pressure
   always_ff @(posedge clk)
      if (i_hit_valid & o_hit_ready)
         rsp_q <= i_hit;

   assign o_rsp_valid = valid_q;
   assign o_rsp       = rsp_q;

endmodule

// ==== icache_settings.svh ====
//////////////////////////////////////////////////
// Instruction cache geometry and bus widths
//////////////////////////////////////////////////
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Physical address and word widths
`define IC_AW 32
`define IC_DW 32

// 16-byte lines, 16 sets, 2 ways
`define IC_P_LINE 4
`define IC_P_SETS 4
`define IC_WAYS 2

// Words per line and its log2
`define IC_BEATS 4
`define IC_P_BEATS 2

`define IC_SETS (1 << `IC_P_SETS)
`define IC_TAG_W (`IC_AW - `IC_P_SETS - `IC_P_LINE)
// Byte offset bits inside one word
`define IC_P_WORD (`IC_P_LINE - `IC_P_BEATS)

`endif

// ==== icache_top.sv ====
//////////////////////////////////////////////////
// Two-way instruction cache top level
// Lookup, refill and response stages
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_top
(
   input  logic                   clk,
   input  logic                   i_arst_n,
   // Fetch request
   input  logic                   i_req_valid,
   input  icache_pkg::fetch_req_t i_req,
   output logic                   o_req_ready,
   // Fetch response
   output logic                   o_rsp_valid,
   output icache_pkg::fetch_rsp_t o_rsp,
   input  logic                   i_rsp_ready,
   // Read address
   output logic                   o_ar_valid,
   output icache_pkg::ar_req_t    o_ar,
   input  logic                   i_ar_ready,
   // Read data
   input  logic                   i_r_valid,
   input  icache_pkg::r_beat_t    i_r,
   output logic                   o_r_ready
);

   logic                   miss_valid;
   logic                   miss_ready;
   icache_pkg::miss_req_t  miss;
   icache_pkg::line_wr_t   line_wr;
   logic                   hit_valid;
   logic                   hit_ready;
   icache_pkg::fetch_rsp_t hit;

   icache_lookup icache_lookup_inst
   (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_req_valid  (i_req_valid),
      .i_req        (i_req),
      .o_req_ready  (o_req_ready),
      .o_miss_valid (miss_valid),
      .o_miss       (miss),
      .i_miss_ready (miss_ready),
      .i_line_wr    (line_wr),
      .o_hit_valid  (hit_valid),
      .o_hit        (hit),
      .i_hit_ready  (hit_ready)
   );

   icache_refill icache_refill_inst
   (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_miss_valid (miss_valid),
      .i_miss       (miss),
      .o_miss_ready (miss_ready),
      .o_ar_valid   (o_ar_valid),
      .o_ar         (o_ar),
      .i_ar_ready   (i_ar_ready),
      .i_r_valid    (i_r_valid),
      .i_r          (i_r),
      .o_r_ready    (o_r_ready),
      .o_line_wr    (line_wr)
   );

   icache_resp icache_resp_inst
   (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_hit_valid  (hit_valid),
      .i_hit        (hit),
      .o_hit_ready  (hit_ready),
      .o_rsp_valid  (o_rsp_valid),
      .o_rsp        (o_rsp),
      .i_rsp_ready  (i_rsp_ready)
   );

endmodule

// ==== tb_icache.sv ====
//////////////////////////////////////////////////
// Testbench for the two-way instruction cache
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "icache_settings.svh"

module tb_icache;

   localparam int          TIMEOUT = 200;
   localparam int          N_REQ   = 64;
   localparam logic [31:0] MEM_XOR = 32'h5EED_0000; // Memory word = address ^ this

   logic clk;
   logic i_arst_n;
   logic i_req_valid;
   logic o_req_ready;
   logic o_rsp_valid;
   logic i_rsp_ready;
   logic o_ar_valid;
   logic i_ar_ready;
   logic i_r_valid;
   logic o_r_ready;
   icache_pkg::fetch_req_t i_req;
   icache_pkg::fetch_rsp_t o_rsp;
   icache_pkg::ar_req_t    o_ar;
   icache_pkg::r_beat_t    i_r;

   logic [15:0] lfsr;
   logic        stall_en, stall_on, bus_on, r_fire, hung;
   logic [1:0]  bus_draw;
   int          err_cnt, n_checks, n_tests, ar_count, miss_cnt;
   logic        mem_busy;
   logic [31:0] mem_addr, warm_addr;
   int          beat;

   // Reference model state
   logic [`IC_TAG_W-1:0] m_tag [`IC_SETS][`IC_WAYS];
   logic                 m_val [`IC_SETS][`IC_WAYS];
   int                   m_ptr;

   icache_pkg::fetch_rsp_t exp_q[$];
   int                     cnt_q[$];   // Miss count when each request was issued
   icache_pkg::ar_req_t    ar_q[$];
   logic [31:0]            addr_list [N_REQ];
   int                     gap_list [N_REQ];

   icache_top icache_top_inst (.*);

   always #20 clk = ~clk;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
         end
      return v;
   endfunction

   // Pool of 3 tags over sets 2, 5, 8, 11
   function automatic logic [31:0] pool_addr(input int t, input int s, input int w);
      return ((32'h00A000 + t * 32'h111) << (`IC_P_SETS + `IC_P_LINE))
             | (32'(s * 3 + 2) << `IC_P_LINE) | (32'(w) << `IC_P_WORD);
   endfunction

   task automatic compare_rsp(input icache_pkg::fetch_rsp_t got,
                              input icache_pkg::fetch_rsp_t exp);
      n_checks++;
      if (got.addr !== exp.addr || got.insn !== exp.insn)
         begin
            err_cnt++;
            $display("ERROR o_rsp got %h_%h exp %h_%h", got.addr, got.insn, exp.addr, exp.insn);
         end
   endtask

   task automatic match_ar(input icache_pkg::ar_req_t got, input icache_pkg::ar_req_t exp);
      n_checks++;
      if (got !== exp)
         begin
            err_cnt++;
            $display("ERROR o_ar got %h/%h exp %h/%h", got.addr, got.len, exp.addr, exp.len);
         end
   endtask

   task automatic expect_bit(input string name, input logic got, input logic exp);
      n_checks++;
      if (got !== exp)
         begin
            err_cnt++;
            $display("ERROR %s got %h exp %h", name, got, exp);
         end
   endtask

   task automatic verify_count(input string name, input int got, input int exp);
      n_checks++;
      if (got != exp)
         begin
            err_cnt++;
            $display("ERROR %s got %h exp %h", name, got, exp);
         end
   endtask

   // Predict hit or miss in request order with round-robin fill
   task automatic model_access(input logic [31:0] addr, output logic hit);
      logic [`IC_TAG_W-1:0] tag;
      int                   set;
      tag = addr[`IC_AW-1 -: `IC_TAG_W];
      set = addr[`IC_P_LINE +: `IC_P_SETS];
      hit = 1'b0;
      for (int w = 0; w < `IC_WAYS; w++)
         if (m_val[set][w] && m_tag[set][w] == tag)
            hit = 1'b1;
      if (!hit)
         begin
            m_tag[set][m_ptr] = tag;
            m_val[set][m_ptr] = 1'b1;
            m_ptr = 1 - m_ptr;
            miss_cnt++;
         end
   endtask

   task automatic send_req(input logic [31:0] addr);
      icache_pkg::fetch_rsp_t r;
      icache_pkg::ar_req_t    a;
      logic                   hit;
      int                     n;
      if (hung)
         return;
      model_access(addr, hit);
      r.addr = addr;
      r.insn = addr ^ MEM_XOR;
      exp_q.push_back(r);
      cnt_q.push_back(miss_cnt);
      if (!hit)
         begin
            a.addr = addr & ~((32'd1 << `IC_P_LINE) - 1);
            a.len  = 8'(`IC_BEATS - 1);
            ar_q.push_back(a);
         end
      i_req_valid = 1'b1;
      i_req.addr  = addr;
      n = 0;
      do
         begin
            @(negedge clk);
            n++;
         end
      while (!o_req_ready && n < TIMEOUT);
      if (!o_req_ready)
         begin
            hung = 1'b1;
            err_cnt++;
            $display("Timeout: request %h never accepted", addr);
         end
      @(posedge clk);
      #2;
      i_req_valid = 1'b0;
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && !hung)
         begin
            @(posedge clk);
            #2;
            n++;
            if (n > TIMEOUT)
               begin
                  hung = 1'b1;
                  err_cnt++;
                  $display("Timeout: %0d responses never arrived", exp_q.size());
               end
         end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n)
         begin
            @(posedge clk);
            #2;
         end
   endtask

   task automatic report_test(input string name, input int err_before);
      n_tests++;
      $display("test %s %0d errors", name, err_cnt - err_before);
   endtask

   task automatic reset_checks();
      int base;
      base = err_cnt;
      repeat (5) @(posedge clk);
      expect_bit("o_req_ready", o_req_ready, 1'b0);
      expect_bit("o_rsp_valid", o_rsp_valid, 1'b0);
      #2;
      i_arst_n = 1'b1;
      expect_bit("o_req_ready", o_req_ready, 1'b0);  // Low until the first edge
      @(posedge clk);
      #2;
      expect_bit("o_req_ready", o_req_ready, 1'b1);
      expect_bit("o_rsp_valid", o_rsp_valid, 1'b0);
      expect_bit("o_ar_valid", o_ar_valid, 1'b0);
      expect_bit("o_r_ready", o_r_ready, 1'b0);
      send_req(pool_addr(0, 0, 0));
      drain();
      verify_count("ar_count", ar_count, 1);
      report_test("reset", base);
   endtask

   // Third tag in set 13 evicts the way under the model pointer
   task automatic round_robin_seq();
      logic [31:0] evicted, kept;
      int          base, start;
      base = err_cnt;
      send_req({24'h0C0001, 4'hD, 4'h0});
      send_req({24'h0C0002, 4'hD, 4'h0});
      drain();
      evicted = {m_tag[13][m_ptr], 4'hD, 4'h8};
      kept    = {m_tag[13][1 - m_ptr], 4'hD, 4'h4};
      send_req({24'h0C0003, 4'hD, 4'hC});
      drain();
      start = ar_count;
      send_req(kept);
      drain();
      verify_count("ar_count", ar_count, start);      // Kept tag hits
      send_req(evicted);
      drain();
      verify_count("ar_count", ar_count, start + 1);
      verify_count("ar_count", ar_count, miss_cnt);
      warm_addr = evicted;
      report_test("round_robin", base);
   endtask

   task automatic hit_latency_seq();
      int base, start;
      base  = err_cnt;
      start = ar_count;
      send_req(warm_addr);
      expect_bit("o_rsp_valid", o_rsp_valid, 1'b0);
      @(posedge clk);
      #2;
      expect_bit("o_rsp_valid", o_rsp_valid, 1'b1);
      drain();
      verify_count("ar_count", ar_count, start);
      report_test("hit_latency", base);
   endtask

   task automatic random_traffic();
      int base;
      base     = err_cnt;
      stall_en = 1'b1;
      for (int k = 0; k < N_REQ && !hung; k++)
         begin
            send_req(addr_list[k]);
            idle_cycles(gap_list[k]);
         end
      drain();
      stall_en = 1'b0;
      verify_count("ar_count", ar_count, miss_cnt);
      report_test("random", base);
   endtask

   // Only bus stimulus draws after time zero
   always @(posedge clk)
      begin
         bus_on   = i_arst_n;
         stall_on = stall_en;
         #2;
         if (!bus_on)
            begin
               i_rsp_ready = 1'b0;
               i_ar_ready  = 1'b0;
               i_r_valid   = 1'b0;
            end
         else
            begin
               bus_draw    = rand_bits(2);
               i_rsp_ready = !stall_on || bus_draw != 2'd0;
               i_ar_ready  = rand_bits(1);
               if (!mem_busy)
                  i_r_valid = 1'b0;
               else if (!i_r_valid || r_fire)    // Valid held until taken
                  begin
                     i_r_valid = rand_bits(2) != 0;
                     i_r.data  = (mem_addr + (32'(beat) << `IC_P_WORD)) ^ MEM_XOR;
                     i_r.last  = (beat == `IC_BEATS - 1);
                  end
            end
      end

   // Handshakes sampled mid-cycle complete at the next edge
   always @(negedge clk)
      begin
         r_fire = i_r_valid && o_r_ready;
         if (o_ar_valid && i_ar_ready)
            begin
               if (ar_q.size() == 0)
                  begin
                     err_cnt++;
                     $display("Read address %h issued with no miss expected", o_ar.addr);
                  end
               else
                  match_ar(o_ar, ar_q.pop_front());
               ar_count++;
               mem_busy = 1'b1;
               mem_addr = o_ar.addr;
               beat     = 0;
            end
         if (r_fire)
            begin
               beat++;
               if (i_r.last)
                  mem_busy = 1'b0;
            end
         if (o_rsp_valid && i_rsp_ready)
            begin
               if (exp_q.size() == 0)
                  begin
                     err_cnt++;
                     $display("Response %h arrived with none expected", o_rsp.addr);
                  end
               else
                  begin
                     compare_rsp(o_rsp, exp_q.pop_front());
                     // Next request may already have sent its miss
                     if (ar_count < cnt_q[0]
                         || ar_count > (cnt_q.size() > 1 ? cnt_q[1] : cnt_q[0]))
                        begin
                           err_cnt++;
                           $display("ERROR ar_count got %h exp %h", ar_count, cnt_q[0]);
                        end
                     void'(cnt_q.pop_front());
                  end
            end
      end

   initial
      begin
         clk         = 1'b0;
         i_arst_n    = 1'b0;
         i_req_valid = 1'b0;
         i_req       = '0;
         i_rsp_ready = 1'b0;
         i_ar_ready  = 1'b0;
         i_r_valid   = 1'b0;
         i_r         = '0;
         stall_en    = 1'b0;
         hung        = 1'b0;
         r_fire      = 1'b0;
         mem_busy    = 1'b0;
         mem_addr    = '0;
         warm_addr   = '0;
         beat        = 0;
         err_cnt     = 0;
         n_checks    = 0;
         n_tests     = 0;
         ar_count    = 0;
         miss_cnt    = 0;
         m_ptr       = 0;
         lfsr        = 16'd10146;
         for (int s = 0; s < `IC_SETS; s++)
            for (int w = 0; w < `IC_WAYS; w++)
               begin
                  m_val[s][w] = 1'b0;
                  m_tag[s][w] = '0;
               end
         // Whole request stream drawn before the clock starts
         for (int k = 0; k < N_REQ; k++)
            begin
               addr_list[k] = pool_addr(rand_bits(2) % 3, rand_bits(2), rand_bits(2));
               gap_list[k]  = rand_bits(1) ? rand_bits(2) : 0;
            end

         reset_checks();
         if (!hung)
            round_robin_seq();
         if (!hung)
            hit_latency_seq();
         if (!hung)
            random_traffic();

         err_cnt += icache_top_inst.tb_icache_properties_inst.fail_cnt;
         $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, err_cnt);
         if (err_cnt == 0)
            $display("SIMULATION PASSED");
         else
            $display("SIMULATION FAILED");
         $finish;
      end

endmodule

// ==== tb_icache_properties.sv ====
//////////////////////////////////////////////////
// Handshake assertions on the cache top level
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_icache_properties
(
   input logic                   clk,
   input logic                   i_arst_n,
   input logic                   o_ar_valid,
   input icache_pkg::ar_req_t    o_ar,
   input logic                   i_ar_ready,
   input logic                   o_r_ready,
   input logic                   o_rsp_valid,
   input icache_pkg::fetch_rsp_t o_rsp,
   input logic                   i_rsp_ready
);

   int fail_cnt = 0;

   // Read address stays put until taken
   ar_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_ar_valid && !i_ar_ready |=> o_ar_valid && $stable(o_ar))
      else
         begin
            fail_cnt++;
            $error("read address valid dropped or address changed before ready");
         end

   rsp_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp))
      else
         begin
            fail_cnt++;
            $error("response valid dropped or payload changed before ready");
         end

   // Data phase opens right after the address handshake
   ar_r_order: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_ar_valid && i_ar_ready |=> o_r_ready && !o_ar_valid)
      else
         begin
            fail_cnt++;
            $error("no data phase after the read address handshake");
         end

endmodule

bind icache_top tb_icache_properties tb_icache_properties_inst (.*);
